//--- src.f
source/conv_pkg.sv
source/conv_config_loader.sv
source/conv_controller.sv
source/row_window_buffer.sv
source/conv_mac.sv
source/conv_top.sv
test/conv_properties.sv
test/conv_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conv_tb -f src.f -o conv_sim

./obj_dir/conv_sim > sim.log 2>&1 || true
cat sim.log

grep -q "test passed" sim.log
echo "simulation passed"

//--- test/conv_tb.sv
module conv_tb import conv_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int DONE_TIMEOUT = 20000;
	localparam logic [31:0] SEED = 32'hf9d4_45b0;

	// taps listed from tap 8 down to tap 0
	string t_name [NUM_TESTS] = '{"identity_5x5", "sobel_7x6", "sat_high_4x4",
		"sat_low_4x4", "single_3x3", "wide_32x6"};
	int t_width [NUM_TESTS] = '{5, 7, 4, 4, 3, 32};
	int t_height [NUM_TESTS] = '{5, 6, 4, 4, 3, 6};
	logic [71:0] t_taps [NUM_TESTS] = '{
		{8'd0, 8'd0, 8'd0, 8'd0, 8'd1, 8'd0, 8'd0, 8'd0, 8'd0},
		{8'd1, 8'd2, 8'd1, 8'd0, 8'd0, 8'd0, 8'hff, 8'hfe, 8'hff},
		{9{8'h7f}},
		{9{8'h80}},
		{8'hf7, 8'd8, 8'hf9, 8'd6, 8'hfb, 8'd4, 8'hfd, 8'd2, 8'hff},
		{8'd0, 8'd1, 8'd0, 8'd1, 8'hfc, 8'd1, 8'd0, 8'd1, 8'd0}
	};

	logic clk;
	logic rst_n = 1'b0;
	logic mem_rvalid = 1'b0;
	logic [31:0] mem_rdata = '0;
	logic mem_rd, mem_wr, busy, done;
	logic [31:0] mem_raddr, mem_waddr, mem_wdata;

	logic [31:0] mem [logic [31:0]]; // config words and images
	logic [31:0] results [logic [31:0]]; // words written by the DUT
	logic [31:0] lat_lfsr = SEED;
	logic [31:0] pix_lfsr = SEED;
	logic [31:0] rd_addr = '0;
	logic [31:0] cur_dst = '0;
	logic [31:0] out_words = '0;
	int rd_wait = 0;
	int rd_cnt = 0;
	int wr_cnt = 0;
	int stray_cnt = 0;
	int done_cnt = 0;
	int proto_errs = 0;
	int start_req = 0;
	int start_ack = 0;
	int errors = 0;
	int runs = 0;
	int failed = 0;

	conv_top u_conv_top (.clk(clk), .rst_n(rst_n), .mem_rd(mem_rd), .mem_raddr(mem_raddr),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .mem_wr(mem_wr),
		.mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .busy(busy), .done(done));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(inout logic [31:0] s, input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], s[0]}; // one step per bit
			s = lfsr_step(s);
		end
		return v;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (a == REG_START)
			return 32'(start_req != start_ack);
		return mem.exists(a) ? mem[a] : 32'd0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		runs++;
		if (errors + proto_errs == errs_before) begin
			$display("PASS %s", name);
		end else begin
			failed++;
			$display("FAIL %s with %0d errors", name, errors + proto_errs - errs_before);
		end
	endtask

	// memory model with one read in flight and 1 to 8 cycles of latency
	always @(posedge clk) begin
		mem_rvalid <= 1'b0;
		if (rd_wait > 0) begin
			rd_wait = rd_wait - 1;
			if (rd_wait == 0) begin
				mem_rvalid <= 1'b1;
				mem_rdata <= read_word(rd_addr);
				if (rd_addr == REG_START && start_req != start_ack)
					start_ack = start_req; // start word reads 1 only once
			end
		end
		if (mem_rd) begin
			if (rd_wait > 0) begin
				$display("Error: read issued while another read is outstanding");
				proto_errs++;
			end
			rd_addr = mem_raddr;
			rd_wait = int'(take_bits(lat_lfsr, 3)) + 1;
			rd_cnt++;
		end
		if (mem_wr) begin
			if (mem_waddr < cur_dst || mem_waddr >= cur_dst + out_words)
				stray_cnt++;
			results[mem_waddr] = mem_wdata;
			wr_cnt++;
		end
		if (done)
			done_cnt++;
	end

	initial begin
		logic [31:0] src;
		logic [31:0] addr;
		int pix [MAX_WIDTH*MAX_WIDTH];
		int w, h, n_err, tap, sum, waited, busy_cycles;
		int rd_base, wr_base, stray_base, done_base;
		logic aborted;
		aborted = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// idle, start word stays 0
		n_err = errors + proto_errs;
		rd_base = rd_cnt;
		busy_cycles = 0;
		repeat (100) begin
			@(negedge clk);
			if (busy || mem_wr) busy_cycles++;
		end
		check_value("idle_poll busy cycles", 32'd0, 32'(busy_cycles));
		if (rd_cnt == rd_base) begin
			$display("Error: idle_poll saw no polling reads of the start word");
			errors++;
		end
		report_test("idle_poll", n_err);

		for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
			@(negedge clk);
			n_err = errors + proto_errs;
			w = t_width[t];
			h = t_height[t];
			src = 32'h100 + 32'(t * 16);
			mem[REG_DIMS] = {16'(h), 16'(w)};
			mem[REG_FILTER0] = t_taps[t][31:0];
			mem[REG_FILTER1] = t_taps[t][63:32];
			mem[REG_FILTER2] = {24'd0, t_taps[t][71:64]};
			mem[REG_SRC] = src;
			mem[REG_DST] = 32'h2000 + 32'(t * 256);
			for (int i = 0; i < w * h; i++) begin
				pix[i] = int'(take_bits(pix_lfsr, 8));
				mem[src + 32'(i)] = 32'(pix[i]);
			end
			cur_dst = mem[REG_DST];
			out_words = 32'((w - 2) * (h - 2));
			wr_base = wr_cnt;
			stray_base = stray_cnt;
			done_base = done_cnt;
			start_req++;
			waited = 0;
			while (!done && waited < DONE_TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			if (!done) begin
				$display("Error: %s timed out waiting for done", t_name[t]);
				errors++;
				aborted = 1'b1;
			end else begin
				repeat (3) @(negedge clk);
				for (int r = 0; r < h - 2; r++) begin
					for (int c = 0; c < w - 2; c++) begin
						sum = 0;
						for (int k = 0; k < 9; k++) begin
							tap = int'($signed(t_taps[t][8*k +: 8])); // row k/3 and col k%3
							sum += tap * pix[(r + k / 3) * w + c + k % 3];
						end
						if (sum < 0) sum = 0;
						else if (sum > 255) sum = 255;
						addr = cur_dst + 32'(r * (w - 2) + c);
						check_value($sformatf("%s @%0h", t_name[t], addr), 32'(sum),
							results.exists(addr) ? results[addr] : 32'hffff_ffff);
					end
				end
				check_value({t_name[t], " writes"}, out_words, 32'(wr_cnt - wr_base));
				check_value({t_name[t], " stray writes"}, 32'd0, 32'(stray_cnt - stray_base));
				check_value({t_name[t], " done pulses"}, 32'd1, 32'(done_cnt - done_base));
			end
			report_test(t_name[t], n_err);
		end

		$display("tests run: %0d, failed: %0d, errors: %0d", runs, failed, errors + proto_errs);
		if (failed == 0 && errors + proto_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- test/conv_properties.sv
module conv_properties (
	input logic clk,
	input logic rst_n,
	input logic mem_rd,
	input logic mem_rvalid,
	input logic mem_wr,
	input logic busy,
	input logic done
);

	logic rd_open; // read issued and answer not back yet

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) rd_open <= 1'b0;
		else if (mem_rd) rd_open <= 1'b1;
		else if (mem_rvalid) rd_open <= 1'b0;
	end

	wr_only_busy: assert property (@(posedge clk) disable iff (!rst_n) mem_wr |-> busy)
		else $error("mem_wr while not busy");

	one_read: assert property (@(posedge clk) disable iff (!rst_n) mem_rd |-> !rd_open)
		else $error("mem_rd before the previous mem_rvalid");

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done held longer than one cycle");

endmodule

bind conv_top conv_properties u_props (.clk(clk), .rst_n(rst_n), .mem_rd(mem_rd),
	.mem_rvalid(mem_rvalid), .mem_wr(mem_wr), .busy(busy), .done(done));

//--- source/conv_top.sv
module conv_top import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic mem_rd,
	output logic [ADDR_W-1:0] mem_raddr,
	input logic mem_rvalid,
	input logic [31:0] mem_rdata,
	output logic mem_wr,
	output logic [ADDR_W-1:0] mem_waddr,
	output logic [31:0] mem_wdata,
	output logic busy,
	output logic done
);

	conv_cfg_t cfg;
	logic ld_rd, ctrl_rd;
	logic [ADDR_W-1:0] ld_raddr, ctrl_raddr;
	logic loading, cfg_start, cfg_done;
	logic row_wr, shift, win_valid;
	logic [1:0] row_slot;
	col_idx_t col_idx;
	logic [ADDR_W-1:0] out_addr;
	pix_col_t col;
	conv_out_t wr_out;

	assign mem_rd = ld_rd | ctrl_rd;
	assign mem_raddr = loading ? ld_raddr : ctrl_raddr; // loader owns the bus
	assign mem_waddr = wr_out.addr;
	assign mem_wdata = {{(32-PIX_W){1'b0}}, wr_out.pix};

	conv_config_loader u_loader (.clk(clk), .rst_n(rst_n), .cfg_start(cfg_start),
		.rvalid(mem_rvalid), .rdata(mem_rdata), .rd(ld_rd), .raddr(ld_raddr),
		.loading(loading), .cfg_done(cfg_done), .cfg(cfg));

	conv_controller u_ctrl (.clk(clk), .rst_n(rst_n), .rvalid(mem_rvalid), .rdata(mem_rdata),
		.cfg_done(cfg_done), .cfg(cfg), .rd(ctrl_rd), .raddr(ctrl_raddr),
		.cfg_start(cfg_start), .row_wr(row_wr), .row_slot(row_slot), .col_idx(col_idx),
		.shift(shift), .win_valid(win_valid), .out_addr(out_addr), .busy(busy), .done(done));

	// fill slot doubles as the oldest row
	row_window_buffer u_buf (.clk(clk), .rst_n(rst_n), .wr(row_wr), .wr_slot(row_slot),
		.wr_col(col_idx), .wr_data(mem_rdata[PIX_W-1:0]), .oldest_slot(row_slot),
		.rd_col(col_idx), .col(col));

	conv_mac u_mac (.clk(clk), .rst_n(rst_n), .col_in(col), .in_valid(shift & win_valid),
		.in_addr(out_addr), .taps(cfg.taps), .wr(mem_wr), .wr_out(wr_out));

endmodule

//--- source/conv_mac.sv
module conv_mac import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input pix_col_t col_in,
	input logic in_valid,
	input logic [ADDR_W-1:0] in_addr,
	input taps_t taps,
	output logic wr,
	output conv_out_t wr_out
);

	pix_col_t col_old; // column c-2
	pix_col_t col_prev; // column c-1
	logic [PIX_W-1:0] pix [NUM_TAPS];
	logic signed [16:0] prod [NUM_TAPS];
	logic signed [19:0] sum;
	logic valid1;
	logic [ADDR_W-1:0] addr1;

	always_comb begin
		pix[0] = col_old.top;
		pix[1] = col_prev.top;
		pix[2] = col_in.top;
		pix[3] = col_old.mid;
		pix[4] = col_prev.mid;
		pix[5] = col_in.mid;
		pix[6] = col_old.bot;
		pix[7] = col_prev.bot;
		pix[8] = col_in.bot;
	end

	// stage 1 products
	always_ff @(posedge clk) begin
		col_old <= col_prev;
		col_prev <= col_in;
		if (in_valid) begin
			addr1 <= in_addr;
			for (int i = 0; i < NUM_TAPS; i++)
				prod[i] <= $signed(taps[i]) * $signed({1'b0, pix[i]});
		end
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_TAPS; i++)
			sum = sum + 20'(prod[i]);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid1 <= 1'b0;
			wr <= 1'b0;
		end else begin
			valid1 <= in_valid;
			wr <= valid1;
		end
	end

	// stage 2 sums and clamps to 0..255
	always_ff @(posedge clk) begin
		if (valid1) begin
			wr_out.addr <= addr1;
			if (sum < 20'sd0) wr_out.pix <= '0;
			else if (sum > 20'sd255) wr_out.pix <= '1;
			else wr_out.pix <= sum[PIX_W-1:0];
		end
	end

endmodule

//--- source/row_window_buffer.sv
module row_window_buffer import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [1:0] wr_slot,
	input col_idx_t wr_col,
	input logic [PIX_W-1:0] wr_data,
	input logic [1:0] oldest_slot,
	input col_idx_t rd_col,
	output pix_col_t col
);

	logic [PIX_W-1:0] rows [3][MAX_WIDTH];
	logic [1:0] mid_slot;
	logic [1:0] new_slot;

	assign mid_slot = next_slot(oldest_slot);
	assign new_slot = next_slot(mid_slot);

	always_ff @(posedge clk) begin
		if (wr) rows[wr_slot][wr_col] <= wr_data;
	end

	// order is fixed at read time so the slot can rotate right after
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
		end else begin
			col.top <= rows[oldest_slot][rd_col];
			col.mid <= rows[mid_slot][rd_col];
			col.bot <= rows[new_slot][rd_col];
		end
	end

endmodule

//--- source/conv_controller.sv
module conv_controller import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rvalid,
	input logic [31:0] rdata,
	input logic cfg_done,
	input conv_cfg_t cfg,
	output logic rd,
	output logic [ADDR_W-1:0] raddr,
	output logic cfg_start,
	output logic row_wr,
	output logic [1:0] row_slot, // next slot to fill is the oldest row
	output col_idx_t col_idx,
	output logic shift, // aligned with the buffer's column
	output logic win_valid,
	output logic [ADDR_W-1:0] out_addr,
	output logic busy,
	output logic done
);

	ctrl_state_e state, next;

	logic pending; // a read is outstanding
	logic [1:0] fill_cnt;
	logic [ADDR_W-1:0] src_ptr; // next pixel to fetch from contiguous rows
	logic [ADDR_W-1:0] out_base; // first result word of current output row
	logic [15:0] rows_left;
	col_idx_t col_q; // column now leaving the buffer
	logic drain_cnt;
	logic last_col;

	assign last_col = (16'(col_idx) == cfg.width - 16'd1);
	assign row_wr = rvalid && (state == FILL_ROWS || state == NEW_ROW);
	assign win_valid = (col_q >= col_idx_t'(2)); // qualifies shift
	assign out_addr = out_base + ADDR_W'(col_q) - ADDR_W'(2);
	assign busy = (state != POLL);
	assign done = (state == DONE);

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n) state <= POLL;
		else state <= next;

	always_comb begin
		next = state;
		case (state)
			POLL: if (rvalid && rdata == 32'd1) next = LOAD_CONFIG;
			LOAD_CONFIG: if (cfg_done) next = FILL_ROWS;
			FILL_ROWS: if (rvalid && last_col && fill_cnt == 2'd2) next = SHIFT;
			NEW_ROW: if (rvalid && last_col) next = SHIFT;
			SHIFT: if (last_col) next = ROW_END;
			ROW_END: next = (rows_left == 16'd1) ? DRAIN : NEW_ROW;
			DRAIN: if (drain_cnt) next = DONE; // MAC needs two cycles
			DONE: next = POLL;
			default: next = POLL;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd <= 1'b0;
			raddr <= '0;
			cfg_start <= 1'b0;
			pending <= 1'b0;
			fill_cnt <= '0;
			row_slot <= '0;
			col_idx <= '0;
			src_ptr <= '0;
			out_base <= '0;
			rows_left <= '0;
			shift <= 1'b0;
			col_q <= '0;
			drain_cnt <= 1'b0;
		end else begin
			rd <= 1'b0;
			cfg_start <= 1'b0;
			shift <= 1'b0;
			if (rvalid) pending <= 1'b0;
			case (state)
				POLL: begin
					if (!pending) begin
						rd <= 1'b1;
						raddr <= REG_START;
						pending <= 1'b1;
					end else if (rvalid && rdata == 32'd1) begin
						cfg_start <= 1'b1;
					end
				end
				LOAD_CONFIG: begin
					if (cfg_done) begin
						src_ptr <= cfg.src;
						out_base <= cfg.dst;
						rows_left <= cfg.height - 16'd2;
						row_slot <= '0;
						fill_cnt <= '0;
						col_idx <= '0;
					end
				end
				FILL_ROWS, NEW_ROW: begin
					if (!pending) begin
						rd <= 1'b1;
						raddr <= src_ptr;
						src_ptr <= src_ptr + ADDR_W'(1);
						pending <= 1'b1;
					end else if (rvalid) begin
						if (last_col) begin
							col_idx <= '0;
							row_slot <= next_slot(row_slot); // rotate
							if (state == FILL_ROWS) fill_cnt <= fill_cnt + 2'd1;
						end else begin
							col_idx <= col_idx + col_idx_t'(1);
						end
					end
				end
				SHIFT: begin
					shift <= 1'b1;
					col_q <= col_idx;
					col_idx <= last_col ? '0 : col_idx + col_idx_t'(1);
				end
				ROW_END: begin
					rows_left <= rows_left - 16'd1;
					out_base <= out_base + ADDR_W'(cfg.width) - ADDR_W'(2);
					drain_cnt <= 1'b0;
				end
				DRAIN: drain_cnt <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

//--- source/conv_config_loader.sv
module conv_config_loader import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic cfg_start,
	input logic rvalid,
	input logic [31:0] rdata,
	output logic rd,
	output logic [ADDR_W-1:0] raddr,
	output logic loading,
	output logic cfg_done,
	output conv_cfg_t cfg
);

	logic [2:0] idx; // offset from REG_DIMS
	logic last_word;

	assign raddr = REG_DIMS + ADDR_W'(idx);
	assign last_word = (raddr == REG_DST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
			rd <= 1'b0;
			loading <= 1'b0;
			cfg_done <= 1'b0;
		end else begin
			rd <= 1'b0;
			cfg_done <= 1'b0;
			if (cfg_start) begin
				loading <= 1'b1;
				idx <= '0;
				rd <= 1'b1;
			end else if (loading && rvalid) begin
				if (last_word) begin
					loading <= 1'b0; // bus goes back to the controller
					cfg_done <= 1'b1;
				end else begin
					idx <= idx + 3'd1;
					rd <= 1'b1; // next word right after the answer
				end
			end
		end
	end

	// unpack each word as it returns
	always_ff @(posedge clk) begin
		if (loading && rvalid) begin
			case (raddr)
				REG_DIMS: begin
					cfg.width <= rdata[15:0];
					cfg.height <= rdata[31:16];
				end
				REG_FILTER0:
					for (int b = 0; b < 4; b++)
						cfg.taps[b] <= rdata[8*b +: 8];
				REG_FILTER1:
					for (int b = 0; b < 4; b++)
						cfg.taps[b+4] <= rdata[8*b +: 8];
				REG_FILTER2: cfg.taps[8] <= rdata[7:0];
				REG_SRC: cfg.src <= rdata;
				REG_DST: cfg.dst <= rdata;
				default: ;
			endcase
		end
	end

endmodule

//--- source/conv_pkg.sv
package conv_pkg;

	localparam int MAX_WIDTH = 32;
	localparam int PIX_W = 8;
	localparam int ADDR_W = 32;
	localparam int COL_W = $clog2(MAX_WIDTH);
	localparam int NUM_TAPS = 9;

	// word addresses of the mapped registers
	localparam logic [ADDR_W-1:0] REG_START = 32'h000;
	localparam logic [ADDR_W-1:0] REG_DIMS = 32'h001; // height[31:16], width[15:0]
	localparam logic [ADDR_W-1:0] REG_FILTER0 = 32'h002; // taps 0..3
	localparam logic [ADDR_W-1:0] REG_FILTER1 = 32'h003; // taps 4..7
	localparam logic [ADDR_W-1:0] REG_FILTER2 = 32'h004; // tap 8 in low byte
	localparam logic [ADDR_W-1:0] REG_SRC = 32'h005;
	localparam logic [ADDR_W-1:0] REG_DST = 32'h006;

	typedef logic signed [PIX_W-1:0] tap_t;
	typedef tap_t [NUM_TAPS-1:0] taps_t; // index is row*3 + col, row 0 oldest
	typedef logic [COL_W-1:0] col_idx_t;

	typedef enum logic [2:0] {
		POLL,
		LOAD_CONFIG,
		FILL_ROWS,
		NEW_ROW,
		SHIFT,
		ROW_END,
		DRAIN,
		DONE
	} ctrl_state_e;

	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
		taps_t taps;
		logic [ADDR_W-1:0] src;
		logic [ADDR_W-1:0] dst;
	} conv_cfg_t;

	typedef struct packed {
		logic [PIX_W-1:0] top; // oldest row
		logic [PIX_W-1:0] mid;
		logic [PIX_W-1:0] bot;
	} pix_col_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [PIX_W-1:0] pix;
	} conv_out_t;

	// three row slots used round robin
	function automatic logic [1:0] next_slot(input logic [1:0] slot);
		return (slot == 2'd2) ? 2'd0 : slot + 2'd1;
	endfunction

endpackage
